// File: verilog.f
hdl/exec_pkg.sv
hdl/alu_path.sv
hdl/branch_resolve.sv
hdl/result_merge.sv
hdl/exec_unit.sv
bench/exec_properties.sv
bench/exec_checker.sv
bench/exec_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the execute unit testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module exec_tb -f verilog.f -o exec_sim \
    && ./obj_dir/exec_sim +verilator+error+limit+1000 | tee sim.log
grep -qs "All tests passed!" sim.log \
    && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }

// File: bench/exec_tb.sv
/* random testbench of the execute unit, LFSR stimulus with random back-pressure.
   one directed item first checks the two-cycle latency */
module exec_tb;
    import exec_pkg::*;

    localparam int NUM_ITEMS  = 3000;
    // cycle limits of the wait loops
    localparam int WAIT_LIMIT = 100;
    localparam int RUN_LIMIT  = NUM_ITEMS * 20;

    logic       clk = 1'b0;
    logic       i_rst_n;
    logic       i_valid;
    logic       o_ready;
    word_t      i_pc;
    word_t      i_da;
    word_t      i_db;
    word_t      i_imm;
    instr_idx_t i_instr_idx;
    alu_func_t  i_alu_func;
    logic       i_alu_imm;
    logic       i_shift_imm;
    logic       i_slt;
    logic       i_slt_signed;
    logic       i_link;
    logic       i_allow_ovf;
    reg_idx_t   i_target_reg;
    br_kind_t   i_br_kind;
    word_t      i_pred_pc;
    exc_code_t  i_exc_in;
    logic       i_canceled;
    logic       o_valid;
    logic       i_ready;
    word_t      o_result;
    reg_idx_t   o_target_reg;
    word_t      o_br_target;
    logic       o_redirect;
    exc_code_t  o_exc;
    logic       o_canceled;

    int          accepted;
    int          delivered;
    int          mismatches;
    int          other_errors;
    int          bench_errors;
    int          timeouts;
    int          assert_fails;
    int          sent;
    int          cycles;
    int          lat;
    logic [31:0] lfsr;

    always #20 clk = ~clk;

    exec_unit u_dut (.*);

    exec_checker u_check (
        .*,
        .i_in_valid       (i_valid),
        .i_in_ready       (o_ready),
        .i_out_valid      (o_valid),
        .i_out_ready      (i_ready),
        .i_result         (o_result),
        .i_res_target_reg (o_target_reg),
        .i_br_target      (o_br_target),
        .i_redirect       (o_redirect),
        .i_exc            (o_exc),
        .i_res_canceled   (o_canceled),
        .o_accepted       (accepted),
        .o_delivered      (delivered),
        .o_mismatches     (mismatches),
        .o_other_errors   (other_errors)
    );

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // n random bits with one LFSR step per bit
    function automatic word_t take_bits(input int n);
        word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[XLEN-2:0], lfsr[0]};
        end
        return v;
    endfunction

    // new random item on the input fields
    task automatic drive_item();
        word_t pc;
        word_t da;
        word_t r;
        pc = take_bits(30) << 2;
        da = take_bits(32);
        // zero rs now and then for the compare-with-zero branches
        if (take_bits(3) == 0) begin
            da = '0;
        end
        r = take_bits(16);
        i_pc         <= pc;
        i_da         <= da;
        // equal operands for BEQ and BNE
        i_db         <= (take_bits(2) == 0) ? da : take_bits(32);
        i_imm        <= {{16{r[15]}}, r[15:0]};
        i_instr_idx  <= instr_idx_t'(take_bits(26));
        i_alu_func   <= alu_func_t'(take_bits(4) % 10);
        i_alu_imm    <= (take_bits(1) != 0);
        i_shift_imm  <= (take_bits(2) == 0);
        i_slt        <= (take_bits(2) == 0);
        i_slt_signed <= (take_bits(1) != 0);
        i_link       <= (take_bits(2) == 0);
        i_allow_ovf  <= (take_bits(1) != 0);
        i_target_reg <= reg_idx_t'(take_bits(5));
        i_br_kind    <= br_kind_t'(take_bits(4) % 11);
        // static not-taken prediction on most items
        i_pred_pc    <= (take_bits(2) != 0) ? pc + INSTR_BYTES : take_bits(32);
        i_exc_in     <= (take_bits(2) == 0) ? exc_code_t'(1 + take_bits(3) % 6) : EXC_NONE;
        i_canceled   <= (take_bits(3) == 0);
    endtask

    initial begin
        lfsr         = 32'h4b42;
        bench_errors = 0;
        timeouts     = 0;
        i_rst_n      = 1'b0;
        i_valid      = 1'b0;
        i_ready      = 1'b0;
        i_pc         = '0;
        i_da         = '0;
        i_db         = '0;
        i_imm        = '0;
        i_instr_idx  = '0;
        i_alu_func   = ALU_ADD;
        i_alu_imm    = 1'b0;
        i_shift_imm  = 1'b0;
        i_slt        = 1'b0;
        i_slt_signed = 1'b0;
        i_link       = 1'b0;
        i_allow_ovf  = 1'b0;
        i_target_reg = '0;
        i_br_kind    = BR_NONE;
        i_pred_pc    = '0;
        i_exc_in     = EXC_NONE;
        i_canceled   = 1'b0;
        repeat (4) @(posedge clk);
        i_rst_n <= 1'b1;

        // single item with downstream always ready
        @(posedge clk);
        i_ready <= 1'b1;
        drive_item();
        i_valid <= 1'b1;
        // unit is empty, so this edge takes the item
        @(posedge clk);
        i_valid <= 1'b0;
        // the cycle that presented the item is cycle 0
        lat = 1;
        @(negedge clk);
        while (!o_valid && lat < WAIT_LIMIT) begin
            @(negedge clk);
            lat++;
        end
        if (lat >= WAIT_LIMIT) begin
            $display("timeout waiting for the first item to come out");
            timeouts++;
        end else if (lat != 2) begin
            $display("first item came out after %0d cycles instead of 2", lat);
            bench_errors++;
        end

        // random valid and ready with fields held while an item waits
        sent = 1;
        cycles = 0;
        while (sent < NUM_ITEMS && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
            if (i_valid && o_ready) begin
                sent++;
            end
            i_ready <= (take_bits(2) != 0);
            if (!i_valid || o_ready) begin
                if (sent < NUM_ITEMS && take_bits(2) != 0) begin
                    drive_item();
                    i_valid <= 1'b1;
                end else begin
                    i_valid <= 1'b0;
                end
            end
        end
        if (cycles >= RUN_LIMIT) begin
            $display("timeout: only %0d of %0d items were accepted", sent, NUM_ITEMS);
            timeouts++;
        end

        // drain whatever is still in flight
        i_valid <= 1'b0;
        i_ready <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (delivered < accepted && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= WAIT_LIMIT) begin
            $display("timeout: %0d items never left the unit", accepted - delivered);
            timeouts++;
        end
        if (accepted != sent) begin
            $display("checker saw %0d accepted items but %0d were sent", accepted, sent);
            bench_errors++;
        end
        if (delivered != accepted) begin
            $display("%0d items accepted but %0d delivered", accepted, delivered);
            bench_errors++;
        end

        assert_fails = u_dut.u_merge.u_props.fail_count;
        $display("errors: %0d mismatches, %0d other, %0d timeouts, %0d assertion failures",
                 mismatches, other_errors + bench_errors, timeouts, assert_fails);
        if (mismatches + other_errors + bench_errors + timeouts + assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: bench/exec_checker.sv
/* reference model and scoreboard of the execute unit.
   counters are written at the rising edge, read them away from it */
module exec_checker
    import exec_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,
    // upstream side
    input  logic       i_in_valid,
    input  logic       i_in_ready,
    input  word_t      i_pc,
    input  word_t      i_da,
    input  word_t      i_db,
    input  word_t      i_imm,
    input  word_t      i_pred_pc,
    input  instr_idx_t i_instr_idx,
    input  alu_func_t  i_alu_func,
    input  logic       i_alu_imm,
    input  logic       i_shift_imm,
    input  logic       i_slt,
    input  logic       i_slt_signed,
    input  logic       i_link,
    input  logic       i_allow_ovf,
    input  reg_idx_t   i_target_reg,
    input  br_kind_t   i_br_kind,
    input  exc_code_t  i_exc_in,
    input  logic       i_canceled,
    // downstream side
    input  logic       i_out_valid,
    input  logic       i_out_ready,
    input  word_t      i_result,
    input  reg_idx_t   i_res_target_reg,
    input  word_t      i_br_target,
    input  logic       i_redirect,
    input  exc_code_t  i_exc,
    input  logic       i_res_canceled,
    // counts
    output int         o_accepted,
    output int         o_delivered,
    output int         o_mismatches,
    output int         o_other_errors
);

    typedef struct packed {
        word_t     result;
        reg_idx_t  target_reg;
        word_t     br_target;
        logic      redirect;
        exc_code_t exc;
        logic      canceled;
    } expect_t;

    // expected items in acceptance order
    expect_t expected_q[$];
    expect_t head;

    // expected outputs of the item on the input ports
    function automatic expect_t model_item();
        expect_t e;
        word_t   a;
        word_t   b;
        word_t   alu;
        word_t   seq;
        longint  wide;
        logic    ovf;
        logic    taken;
        a = i_shift_imm ? word_t'(i_imm[10:6]) : i_da;
        b = i_alu_imm ? i_imm : i_db;
        ovf = 1'b0;
        case (i_alu_func)
            ALU_ADD, ALU_SUB: begin
                // exact 64-bit result overflows when it does not fit 32 signed bits
                if (i_alu_func == ALU_ADD) begin
                    wide = longint'($signed(a)) + longint'($signed(b));
                end else begin
                    wide = longint'($signed(a)) - longint'($signed(b));
                end
                alu = wide[31:0];
                ovf = (wide != longint'($signed(alu)));
            end
            ALU_AND: alu = a & b;
            ALU_OR:  alu = a | b;
            ALU_XOR: alu = a ^ b;
            ALU_NOR: alu = ~(a | b);
            ALU_SLL: alu = b << a[4:0];
            ALU_SRL: alu = b >> a[4:0];
            // logical shift with the vacated top bits filled from the sign
            ALU_SRA: alu = (b >> a[4:0]) | (b[31] ? ~(32'hffff_ffff >> a[4:0]) : 32'h0);
            ALU_LUI: alu = i_imm << 16;
            default: alu = '0;
        endcase
        if (i_link) begin
            e.result = i_pc + 32'd4;
        end else if (i_slt) begin
            e.result = i_slt_signed ? word_t'($signed(a) < $signed(b)) : word_t'(a < b);
        end else begin
            e.result = alu;
        end
        e.target_reg = i_link ? 5'd31 : i_target_reg;
        // branch conditions on rs as a signed value
        seq = i_pc + 32'd4;
        case (i_br_kind)
            BR_BEQ:  taken = (i_da == i_db);
            BR_BNE:  taken = (i_da != i_db);
            BR_BGEZ: taken = ($signed(i_da) >= 0);
            BR_BLTZ: taken = ($signed(i_da) < 0);
            BR_BLEZ: taken = ($signed(i_da) <= 0);
            BR_BGTZ: taken = ($signed(i_da) > 0);
            default: taken = 1'b0;
        endcase
        case (i_br_kind)
            BR_J, BR_JAL:   e.br_target = {i_pc[31:28], i_instr_idx, 2'b00};
            BR_JR, BR_JALR: e.br_target = i_da;
            default:        e.br_target = taken ? seq + (i_imm << 2) : seq;
        endcase
        e.canceled = i_canceled;
        e.redirect = !i_canceled && (i_br_kind != BR_NONE) && (e.br_target != i_pred_pc);
        e.exc = (!i_canceled && i_allow_ovf && ovf) ? EXC_OVERFLOW : i_exc_in;
        return e;
    endfunction

    task automatic check_field(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch %s item %0d: got %h expected %h", name, o_delivered, got, exp);
            o_mismatches++;
        end
    endtask

    always @(posedge clk) begin
        if (!i_rst_n) begin
            expected_q.delete();
            o_accepted     = 0;
            o_delivered    = 0;
            o_mismatches   = 0;
            o_other_errors = 0;
        end else begin
            // oldest item leaves before a new one is queued
            if (i_out_valid && i_out_ready) begin
                if (expected_q.size() == 0) begin
                    $display("output item %0d came out with no item accepted", o_delivered);
                    o_other_errors++;
                end else begin
                    head = expected_q.pop_front();
                    check_field("o_result", i_result, head.result);
                    check_field("o_target_reg", word_t'(i_res_target_reg),
                                word_t'(head.target_reg));
                    check_field("o_br_target", i_br_target, head.br_target);
                    check_field("o_redirect", word_t'(i_redirect), word_t'(head.redirect));
                    check_field("o_exc", word_t'(i_exc), word_t'(head.exc));
                    check_field("o_canceled", word_t'(i_res_canceled), word_t'(head.canceled));
                end
                o_delivered++;
            end
            if (i_in_valid && i_in_ready) begin
                expected_q.push_back(model_item());
                o_accepted++;
            end
        end
    end

endmodule

// File: bench/exec_properties.sv
/* handshake properties of the merge stage, bound into result_merge.
   fail_count is read by the testbench for the closing report */
module exec_properties
    import exec_pkg::*;
(
    input logic                clk,
    input logic                i_rst_n,
    input logic                i_s1_valid,
    input logic                i_out_valid,
    input logic                i_out_ready,
    input logic                i_in_ready,
    // result, branch target, target reg, redirect, cancel and exception
    input logic [2*XLEN+10:0]  i_payload
);

    int fail_count = 0;

    // synchronous reset empties the output register
    assert property (@(posedge clk) !i_rst_n |=> !i_out_valid)
        else begin
            $error("o_valid still high one cycle after reset");
            fail_count++;
        end

    // a stalled output keeps its item and its value
    assert property (@(posedge clk) disable iff (!i_rst_n)
        i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_payload))
        else begin
            $error("output item changed or dropped under back-pressure");
            fail_count++;
        end

    // no room only with a full stage 1, which then keeps its item
    assert property (@(posedge clk) disable iff (!i_rst_n)
        !i_in_ready |=> $past(i_s1_valid) && i_s1_valid)
        else begin
            $error("o_ready low with stage 1 empty, or stage 1 lost its item");
            fail_count++;
        end

endmodule

bind result_merge exec_properties u_props (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_s1_valid  (s1_valid),
    .i_out_valid (o_valid),
    .i_out_ready (i_ready),
    .i_in_ready  (o_ready),
    .i_payload   ({o_result, o_br_target, o_target_reg, o_redirect, o_canceled, o_exc})
);

// File: hdl/exec_unit.sv
/* execute unit top, two-cycle latency with one item per cycle throughput.
   o_redirect asks upstream to refetch from o_br_target */
module exec_unit
    import exec_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,
    // upstream handshake
    input  logic       i_valid,
    output logic       o_ready,
    // operands
    input  word_t      i_pc,
    input  word_t      i_da,
    input  word_t      i_db,
    input  word_t      i_imm,
    input  instr_idx_t i_instr_idx,
    // ALU controls
    input  alu_func_t  i_alu_func,
    input  logic       i_alu_imm,
    input  logic       i_shift_imm,
    input  logic       i_slt,
    input  logic       i_slt_signed,
    input  logic       i_link,
    input  logic       i_allow_ovf,
    // register and branch fields
    input  reg_idx_t   i_target_reg,
    input  br_kind_t   i_br_kind,
    input  word_t      i_pred_pc,
    // status from earlier stages
    input  exc_code_t  i_exc_in,
    input  logic       i_canceled,
    // downstream handshake
    output logic       o_valid,
    input  logic       i_ready,
    // results
    output word_t      o_result,
    output reg_idx_t   o_target_reg,
    output word_t      o_br_target,
    output logic       o_redirect,
    output exc_code_t  o_exc,
    output logic       o_canceled
);

    // stage-1 load strobe from the merge control
    logic     s1_advance;
    // stage-1 path results
    word_t    s1_result;
    reg_idx_t s1_target_reg;
    logic     s1_overflow;
    word_t    s1_br_target;
    logic     s1_mispredict;

    alu_path u_alu (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_advance    (s1_advance),
        .i_pc         (i_pc),
        .i_da         (i_da),
        .i_db         (i_db),
        .i_imm        (i_imm),
        .i_alu_func   (i_alu_func),
        .i_alu_imm    (i_alu_imm),
        .i_shift_imm  (i_shift_imm),
        .i_slt        (i_slt),
        .i_slt_signed (i_slt_signed),
        .i_link       (i_link),
        .i_allow_ovf  (i_allow_ovf),
        .i_target_reg (i_target_reg),
        .o_result     (s1_result),
        .o_target_reg (s1_target_reg),
        .o_overflow   (s1_overflow)
    );

    branch_resolve u_branch (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_advance    (s1_advance),
        .i_pc         (i_pc),
        .i_da         (i_da),
        .i_db         (i_db),
        .i_imm        (i_imm),
        .i_pred_pc    (i_pred_pc),
        .i_instr_idx  (i_instr_idx),
        .i_br_kind    (i_br_kind),
        .o_br_target  (s1_br_target),
        .o_mispredict (s1_mispredict)
    );

    result_merge u_merge (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_valid         (i_valid),
        .i_ready         (i_ready),
        .o_ready         (o_ready),
        .o_valid         (o_valid),
        .o_advance       (s1_advance),
        .i_canceled      (i_canceled),
        .i_exc_in        (i_exc_in),
        .i_s1_result     (s1_result),
        .i_s1_target_reg (s1_target_reg),
        .i_s1_overflow   (s1_overflow),
        .i_s1_mispredict (s1_mispredict),
        .i_s1_br_target  (s1_br_target),
        .o_result        (o_result),
        .o_br_target     (o_br_target),
        .o_target_reg    (o_target_reg),
        .o_redirect      (o_redirect),
        .o_canceled      (o_canceled),
        .o_exc           (o_exc)
    );

endmodule

// File: hdl/result_merge.sv
/* valid/ready control of both stages and the output register.
   cancel masks overflow and redirect but the item still leaves the unit */
module result_merge
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst_n,
    input  logic      i_valid,
    input  logic      i_ready,
    output logic      o_ready,
    output logic      o_valid,
    output logic      o_advance,
    input  logic      i_canceled,
    input  exc_code_t i_exc_in,
    input  word_t     i_s1_result,
    input  reg_idx_t  i_s1_target_reg,
    input  logic      i_s1_overflow,
    input  logic      i_s1_mispredict,
    input  word_t     i_s1_br_target,
    output word_t     o_result,
    output word_t     o_br_target,
    output reg_idx_t  o_target_reg,
    output logic      o_redirect,
    output logic      o_canceled,
    output exc_code_t o_exc
);

    logic      s1_valid;
    logic      s1_canceled;
    exc_code_t s1_exc_in;
    logic      s1_move;
    logic      out_load;
    logic      ovf_taken;

    // output register is free, or its item leaves this edge
    assign s1_move = !o_valid || i_ready;

    // room in stage 1 when empty or when it can hand off
    assign o_ready = !s1_valid || s1_move;

    // paths load on every accepted item
    assign o_advance = i_valid && o_ready;

    // stage 1 holds a real item that moves on
    assign out_load = s1_valid && s1_move;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            s1_valid <= 1'b0;
            o_valid  <= 1'b0;
        end else begin
            // with room, stage 1 takes whatever is offered
            if (o_ready) begin
                s1_valid <= i_valid;
            end
            // output register follows stage 1 when it may move
            if (s1_move) begin
                o_valid <= s1_valid;
            end
        end
    end

    // stage-1 copies of the status fields
    always_ff @(posedge clk) begin
        if (o_advance) begin
            s1_canceled <= i_canceled;
            s1_exc_in   <= i_exc_in;
        end
    end

    // overflow wins over earlier codes, but only for live items
    assign ovf_taken = i_s1_overflow && !s1_canceled;

    // output register, held while downstream stalls
    always_ff @(posedge clk) begin
        if (out_load) begin
            o_result     <= i_s1_result;
            o_target_reg <= i_s1_target_reg;
            o_br_target  <= i_s1_br_target;
            o_redirect   <= i_s1_mispredict && !s1_canceled;
            o_canceled   <= s1_canceled;
            o_exc        <= ovf_taken ? EXC_OVERFLOW : s1_exc_in;
        end
    end

endmodule

// File: hdl/branch_resolve.sv
/* stage-1 branch resolution against the predicted next PC.
   i_imm is taken as already sign-extended to XLEN by the decoder */
module branch_resolve
    import exec_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic       i_advance,
    input  word_t      i_pc,
    input  word_t      i_da,
    input  word_t      i_db,
    input  word_t      i_imm,
    input  word_t      i_pred_pc,
    input  instr_idx_t i_instr_idx,
    input  br_kind_t   i_br_kind,
    output word_t      o_br_target,
    output logic       o_mispredict
);

    word_t seq_pc;
    word_t jump_pc;
    word_t cond_pc;
    word_t target_d;
    logic  da_zero;
    logic  da_neg;
    logic  da_eq_db;
    logic  taken;
    logic  mispredict_d;

    // fall-through address, no delay slot
    assign seq_pc = i_pc + INSTR_BYTES;

    // region jump keeps the top 4 bits of the branch's own PC
    assign jump_pc = {i_pc[XLEN-1:XLEN-4], i_instr_idx, 2'b00};

    // word offset relative to the next instruction
    assign cond_pc = seq_pc + {i_imm[XLEN-3:0], 2'b00};

    // condition flags on rs, and rs against rt
    assign da_zero  = (i_da == '0);
    assign da_neg   = i_da[XLEN-1];
    assign da_eq_db = (i_da == i_db);

    always_comb begin
        case (i_br_kind)
            BR_BEQ:  taken = da_eq_db;
            BR_BNE:  taken = !da_eq_db;
            BR_BGEZ: taken = !da_neg;
            BR_BLTZ: taken = da_neg;
            BR_BLEZ: taken = da_neg | da_zero;
            BR_BGTZ: taken = !da_neg && !da_zero;
            default: taken = 1'b0;
        endcase
    end

    // target select, unconditional kinds first
    always_comb begin
        case (i_br_kind)
            BR_J, BR_JAL:   target_d = jump_pc;
            // register jumps go to rs as is
            BR_JR, BR_JALR: target_d = i_da;
            default:        target_d = taken ? cond_pc : seq_pc;
        endcase
    end

    // a not-taken branch still mispredicts if the predictor guessed taken
    assign mispredict_d = (i_br_kind != BR_NONE) && (target_d != i_pred_pc);

    always_ff @(posedge clk) begin
        if (i_advance) begin
            o_br_target <= target_d;
        end
    end

    // mispredict flag, cleared at reset
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_mispredict <= 1'b0;
        end else if (i_advance) begin
            o_mispredict <= mispredict_d;
        end
    end

endmodule

// File: hdl/alu_path.sv
/* stage-1 ALU path, result and target register registered on i_advance.
   overflow is raised for ADD/SUB only and is not masked by cancel here */
module alu_path
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst_n,
    input  logic      i_advance,
    input  word_t     i_pc,
    input  word_t     i_da,
    input  word_t     i_db,
    input  word_t     i_imm,
    input  alu_func_t i_alu_func,
    input  logic      i_alu_imm,
    input  logic      i_shift_imm,
    input  logic      i_slt,
    input  logic      i_slt_signed,
    input  logic      i_link,
    input  logic      i_allow_ovf,
    input  reg_idx_t  i_target_reg,
    output word_t     o_result,
    output reg_idx_t  o_target_reg,
    output logic      o_overflow
);

    word_t    op_a;
    word_t    op_b;
    word_t    sum;
    word_t    diff;
    word_t    alu_out;
    word_t    result_d;
    logic     add_ovf;
    logic     sub_ovf;
    logic     alu_ovf;
    logic     lt_signed;
    logic     lt_unsigned;
    reg_idx_t target_d;

    // operand A is the shamt field for immediate shifts
    assign op_a = i_shift_imm ? {{(XLEN-5){1'b0}}, i_imm[10:6]} : i_da;
    assign op_b = i_alu_imm ? i_imm : i_db;

    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;

    // signed overflow when operand signs agree and the result sign differs
    assign add_ovf = (op_a[XLEN-1] == op_b[XLEN-1]) && (sum[XLEN-1] != op_a[XLEN-1]);
    // for subtract the operand signs must differ
    assign sub_ovf = (op_a[XLEN-1] != op_b[XLEN-1]) && (diff[XLEN-1] != op_a[XLEN-1]);

    always_comb begin
        alu_ovf = 1'b0;
        case (i_alu_func)
            ALU_ADD: begin
                alu_out = sum;
                alu_ovf = add_ovf;
            end
            ALU_SUB: begin
                alu_out = diff;
                alu_ovf = sub_ovf;
            end
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_NOR: alu_out = ~(op_a | op_b);
            // shifts move operand B by the low 5 bits of operand A
            ALU_SLL: alu_out = op_b << op_a[4:0];
            ALU_SRL: alu_out = op_b >> op_a[4:0];
            ALU_SRA: alu_out = word_t'($signed(op_b) >>> op_a[4:0]);
            // upper immediate, low half cleared
            ALU_LUI: alu_out = {i_imm[15:0], 16'h0000};
            default: alu_out = '0;
        endcase
    end

    // comparators work on the selected operands, like the ALU
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    // output mux with link first, then set-less-than, then ALU
    always_comb begin
        if (i_link) begin
            result_d = i_pc + INSTR_BYTES;
        end else if (i_slt) begin
            result_d = {{(XLEN-1){1'b0}}, i_slt_signed ? lt_signed : lt_unsigned};
        end else begin
            result_d = alu_out;
        end
    end

    // jal/jalr always write r31
    assign target_d = i_link ? LINK_REG : i_target_reg;

    // payload of the stage-1 register
    always_ff @(posedge clk) begin
        if (i_advance) begin
            o_result     <= result_d;
            o_target_reg <= target_d;
        end
    end

    // overflow flag of the stage-1 register
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_overflow <= 1'b0;
        end else if (i_advance) begin
            o_overflow <= i_allow_ovf & alu_ovf;
        end
    end

endmodule

// File: hdl/exec_pkg.sv
/* shared widths, ALU/branch encodings and exception codes of the execute unit.
   exception codes 1 to 6 come from earlier stages and are never produced here */
package exec_pkg;

    // data path and address width
    localparam int XLEN = 32;

    // sequential PC step, one 32-bit instruction
    localparam int INSTR_BYTES = 4;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [25:0]     instr_idx_t;

    // register written by jump-and-link
    localparam reg_idx_t LINK_REG = 5'd31;

    // ALU operations, codes 10..15 unused
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_NOR = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7,
        ALU_SRA = 4'd8,
        ALU_LUI = 4'd9
    } alu_func_t;

    // branch kinds, the and-link conditional forms are not separate here
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_J    = 4'd1,
        BR_JAL  = 4'd2,
        BR_JR   = 4'd3,
        BR_JALR = 4'd4,
        BR_BEQ  = 4'd5,
        BR_BNE  = 4'd6,
        BR_BGEZ = 4'd7,
        BR_BLTZ = 4'd8,
        BR_BLEZ = 4'd9,
        BR_BGTZ = 4'd10
    } br_kind_t;

    // exception cause codes
    typedef enum logic [3:0] {
        EXC_NONE        = 4'd0,
        EXC_IA_MISALIGN = 4'd1,
        EXC_IMMU_MISS   = 4'd2,
        EXC_SYSCALL     = 4'd3,
        EXC_UNIMP       = 4'd4,
        EXC_BREAK       = 4'd5,
        EXC_PRIV        = 4'd6,
        EXC_OVERFLOW    = 4'd7
    } exc_code_t;

endpackage
